//--- hw/udp_echo_pkg.sv
package udp_echo_pkg;

    // Field widths with a meaning of their own
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_len_t;
    typedef logic [7:0]  ip_ttl_t;
    typedef logic [63:0] beat_data_t;
    typedef logic [7:0]  beat_keep_t;
    typedef logic [7:0]  led_byte_t;

    // One payload beat, 74 bits
    typedef struct packed {
        beat_data_t data;
        beat_keep_t keep;
        logic       last;
        logic       user;   // error mark, carried through untouched
    } payload_beat_t;

    // Parsed UDP header as delivered by the receive stack, 112 bits
    typedef struct packed {
        ip_addr_t  source_ip;
        ip_addr_t  dest_ip;
        udp_port_t source_port;
        udp_port_t dest_port;
        udp_len_t  length;
    } udp_hdr_t;

    // Header handed to the transmit stack, 136 bits
    typedef struct packed {
        ip_ttl_t     ttl;
        ip_addr_t    source_ip;
        ip_addr_t    dest_ip;
        udp_port_t   source_port;
        udp_port_t   dest_port;
        udp_len_t    length;
        logic [15:0] checksum;
    } reply_hdr_t;

    typedef enum logic [1:0] {
        IDLE,
        FORWARD,
        DROP
    } echo_state_t;

    localparam udp_port_t ECHO_PORT   = 16'd1234;
    localparam ip_addr_t  LOCAL_IP    = {8'd192, 8'd168, 8'd1, 8'd128};
    localparam ip_ttl_t   REPLY_TTL   = 8'd64;
    localparam int        FIFO_DEPTH  = 16;
    localparam int        FIFO_ADDR_W = 4;
    localparam int        FIFO_CNT_W  = 5;

endpackage

//--- hw/echo_ctrl.sv
`timescale 1ns/1ps

module echo_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  udp_echo_pkg::udp_port_t rx_hdr_dest_port,
    input  logic                  rx_hdr_valid,
    output logic                  rx_hdr_ready,
    input  logic                  rx_payload_valid,
    input  logic                  rx_payload_last,
    output logic                  rx_payload_ready,
    input  logic                  hdr_pending,
    input  logic                  fifo_full,
    output logic                  hdr_load,
    output logic                  fifo_wr
);

    udp_echo_pkg::echo_state_t state;
    udp_echo_pkg::echo_state_t state_next;

    logic port_match;
    logic hdr_xfer;
    logic payload_xfer;

    assign port_match = (rx_hdr_dest_port == udp_echo_pkg::ECHO_PORT);

    // Only take a new header once the previous reply has left
    assign rx_hdr_ready = !rst && (state == udp_echo_pkg::IDLE) && !hdr_pending;
    assign hdr_xfer     = rx_hdr_valid && rx_hdr_ready;
    assign hdr_load     = hdr_xfer && port_match;

    always_comb begin
        case (state)
            udp_echo_pkg::FORWARD: rx_payload_ready = !fifo_full;
            udp_echo_pkg::DROP:    rx_payload_ready = 1'b1;
            default:               rx_payload_ready = 1'b0;
        endcase
    end

    assign payload_xfer = rx_payload_valid && rx_payload_ready;

    // Dropped beats are accepted here and never reach the FIFO
    assign fifo_wr = payload_xfer && (state == udp_echo_pkg::FORWARD);

    always_comb begin
        state_next = state;
        case (state)
            udp_echo_pkg::IDLE: begin
                if (hdr_xfer) begin
                    if (port_match) begin
                        state_next = udp_echo_pkg::FORWARD;
                    end else begin
                        state_next = udp_echo_pkg::DROP;
                    end
                end
            end
            udp_echo_pkg::FORWARD,
            udp_echo_pkg::DROP: begin
                // Frame ends with the beat carrying last
                if (payload_xfer && rx_payload_last) begin
                    state_next = udp_echo_pkg::IDLE;
                end
            end
            default: begin
                state_next = udp_echo_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= udp_echo_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

//--- hw/reply_hdr_builder.sv
`timescale 1ns/1ps

module reply_hdr_builder (
    input  logic                     clk,
    input  logic                     rst,
    input  udp_echo_pkg::udp_hdr_t   rx_hdr,
    input  logic                     hdr_load,
    output udp_echo_pkg::reply_hdr_t tx_hdr,
    output logic                     tx_hdr_valid,
    input  logic                     tx_hdr_ready,
    output logic                     hdr_pending
);

    udp_echo_pkg::reply_hdr_t hdr_reg;
    logic                     pending;

    // Reply fields, captured on a matching header
    always_ff @(posedge clk) begin
        if (hdr_load) begin
            hdr_reg.ttl         <= udp_echo_pkg::REPLY_TTL;
            hdr_reg.source_ip   <= udp_echo_pkg::LOCAL_IP;
            hdr_reg.dest_ip     <= rx_hdr.source_ip;
            // Swap ports so the reply goes back to the sender
            hdr_reg.source_port <= rx_hdr.dest_port;
            hdr_reg.dest_port   <= rx_hdr.source_port;
            hdr_reg.length      <= rx_hdr.length;
            hdr_reg.checksum    <= 16'h0000;
        end
    end

    // Controller never loads while a reply is still waiting
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (hdr_load) begin
            pending <= 1'b1;
        end else if (pending && tx_hdr_ready) begin
            pending <= 1'b0;
        end
    end

    assign tx_hdr       = hdr_reg;
    assign tx_hdr_valid = pending;
    assign hdr_pending  = pending;

endmodule

//--- hw/payload_fifo.sv
`timescale 1ns/1ps

module payload_fifo (
    input  logic                        clk,
    input  logic                        rst,
    input  udp_echo_pkg::payload_beat_t wr_beat,
    input  logic                        wr_en,
    output logic                        full,
    output udp_echo_pkg::payload_beat_t rd_beat,
    output logic                        rd_valid,
    input  logic                        rd_ready
);

    localparam logic [udp_echo_pkg::FIFO_CNT_W-1:0] CNT_FULL =
        udp_echo_pkg::FIFO_CNT_W'(udp_echo_pkg::FIFO_DEPTH);

    udp_echo_pkg::payload_beat_t mem [udp_echo_pkg::FIFO_DEPTH];

    logic [udp_echo_pkg::FIFO_ADDR_W-1:0] wr_ptr;
    logic [udp_echo_pkg::FIFO_ADDR_W-1:0] rd_ptr;
    logic [udp_echo_pkg::FIFO_CNT_W-1:0]  count;

    logic do_wr;
    logic do_rd;

    assign full     = (count == CNT_FULL);
    assign rd_valid = (count != '0);

    // Writes into a full FIFO are ignored
    assign do_wr = wr_en && !full;
    assign do_rd = rd_valid && rd_ready;

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_beat;
        end
    end

    // Head of the queue is always presented on the output
    assign rd_beat = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- hw/led_capture.sv
`timescale 1ns/1ps

module led_capture (
    input  logic                     clk,
    input  logic                     rst,
    input  udp_echo_pkg::beat_data_t beat_data,
    input  logic                     beat_last,
    input  logic                     beat_valid,
    input  logic                     beat_ready,
    output udp_echo_pkg::led_byte_t  led
);

    logic beat_taken;
    logic frame_start;

    assign beat_taken = beat_valid && beat_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_start <= 1'b1;
            led         <= '0;
        end else if (beat_taken) begin
            // Next beat after last opens a new frame
            frame_start <= beat_last;
            if (frame_start) begin
                led <= beat_data[7:0];
            end
        end
    end

endmodule

//--- hw/udp_echo_core.sv
`timescale 1ns/1ps

module udp_echo_core (
    input  logic                        clk,
    input  logic                        rst,

    // Parsed UDP header and payload from the receive side
    input  udp_echo_pkg::udp_hdr_t      rx_hdr,
    input  logic                        rx_hdr_valid,
    output logic                        rx_hdr_ready,
    input  udp_echo_pkg::payload_beat_t rx_payload,
    input  logic                        rx_payload_valid,
    output logic                        rx_payload_ready,

    // Reply towards the transmit side
    output udp_echo_pkg::reply_hdr_t    tx_hdr,
    output logic                        tx_hdr_valid,
    input  logic                        tx_hdr_ready,
    output udp_echo_pkg::payload_beat_t tx_payload,
    output logic                        tx_payload_valid,
    input  logic                        tx_payload_ready,

    output udp_echo_pkg::led_byte_t     led
);

    logic hdr_load;
    logic hdr_pending;
    logic fifo_wr;
    logic fifo_full;

    echo_ctrl u_echo_ctrl (
        .clk              (clk),
        .rst              (rst),
        .rx_hdr_dest_port (rx_hdr.dest_port),
        .rx_hdr_valid     (rx_hdr_valid),
        .rx_hdr_ready     (rx_hdr_ready),
        .rx_payload_valid (rx_payload_valid),
        .rx_payload_last  (rx_payload.last),
        .rx_payload_ready (rx_payload_ready),
        .hdr_pending      (hdr_pending),
        .fifo_full        (fifo_full),
        .hdr_load         (hdr_load),
        .fifo_wr          (fifo_wr)
    );

    reply_hdr_builder u_reply_hdr_builder (
        .clk          (clk),
        .rst          (rst),
        .rx_hdr       (rx_hdr),
        .hdr_load     (hdr_load),
        .tx_hdr       (tx_hdr),
        .tx_hdr_valid (tx_hdr_valid),
        .tx_hdr_ready (tx_hdr_ready),
        .hdr_pending  (hdr_pending)
    );

    // Payload of matching frames only, written under controller gating
    payload_fifo u_payload_fifo (
        .clk      (clk),
        .rst      (rst),
        .wr_beat  (rx_payload),
        .wr_en    (fifo_wr),
        .full     (fifo_full),
        .rd_beat  (tx_payload),
        .rd_valid (tx_payload_valid),
        .rd_ready (tx_payload_ready)
    );

    // Watches the transmit channel only
    led_capture u_led_capture (
        .clk        (clk),
        .rst        (rst),
        .beat_data  (tx_payload.data),
        .beat_last  (tx_payload.last),
        .beat_valid (tx_payload_valid),
        .beat_ready (tx_payload_ready),
        .led        (led)
    );

endmodule

//--- tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Held over four rising edges, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

//--- tests/udp_echo_tb.sv
`timescale 1ns/1ps

module udp_echo_tb;

    localparam int CLK_PERIOD_NS   = 4;
    localparam int HANDSHAKE_LIMIT = 200;
    // Beats over all six tests
    localparam int TOTAL_BEATS     = 5 + 4 + 3 + 20 + 2 + 2 + 4 + 3;
    localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 20 + 300;

    logic                        clk;
    logic                        rst;
    udp_echo_pkg::udp_hdr_t      rx_hdr;
    logic                        rx_hdr_valid;
    logic                        rx_hdr_ready;
    udp_echo_pkg::payload_beat_t rx_payload;
    logic                        rx_payload_valid;
    logic                        rx_payload_ready;
    udp_echo_pkg::reply_hdr_t    tx_hdr;
    logic                        tx_hdr_valid;
    logic                        tx_hdr_ready;
    udp_echo_pkg::payload_beat_t tx_payload;
    logic                        tx_payload_valid;
    logic                        tx_payload_ready;
    udp_echo_pkg::led_byte_t     led;

    udp_echo_pkg::reply_hdr_t    hdr_q[$];
    udp_echo_pkg::payload_beat_t beat_q[$];
    logic [15:0]                 lfsr_state = 16'd16525;
    logic                        saw_rx_stall = 1'b0;
    int                          errors = 0;
    int                          checks = 0;
    int                          tests_run = 0;
    int                          tests_failed = 0;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS)) u_clock_gen (.clk(clk), .rst(rst));

    udp_echo_core u_udp_echo_core (
        .clk              (clk),
        .rst              (rst),
        .rx_hdr           (rx_hdr),
        .rx_hdr_valid     (rx_hdr_valid),
        .rx_hdr_ready     (rx_hdr_ready),
        .rx_payload       (rx_payload),
        .rx_payload_valid (rx_payload_valid),
        .rx_payload_ready (rx_payload_ready),
        .tx_hdr           (tx_hdr),
        .tx_hdr_valid     (tx_hdr_valid),
        .tx_hdr_ready     (tx_hdr_ready),
        .tx_payload       (tx_payload),
        .tx_payload_valid (tx_payload_valid),
        .tx_payload_ready (tx_payload_ready),
        .led              (led)
    );

    // Transmit side transfers, collected as they happen
    always @(posedge clk) begin
        if (!rst) begin
            if (tx_hdr_valid && tx_hdr_ready) begin
                hdr_q.push_back(tx_hdr);
            end
            if (tx_payload_valid && tx_payload_ready) begin
                beat_q.push_back(tx_payload);
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
        $display("watchdog expired, the run did not finish in time");
        $display("SOME TESTS FAILED");
        $finish;
    end

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] random_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic udp_echo_pkg::udp_hdr_t make_hdr(input logic [15:0] port);
        udp_echo_pkg::udp_hdr_t h;
        h.source_ip   = 32'(random_bits(32));
        h.dest_ip     = 32'hC0A8_0180;
        h.source_port = 16'(random_bits(16));
        h.dest_port   = port;
        h.length      = 16'(random_bits(16));
        return h;
    endfunction

    task automatic build_frame(input int n, output udp_echo_pkg::payload_beat_t beats[$]);
        udp_echo_pkg::payload_beat_t b;
        beats = {};
        for (int i = 0; i < n; i++) begin
            b.data = random_bits(64);
            b.keep = (i == n - 1) ? (8'(random_bits(8)) | 8'h01) : 8'hFF;
            b.last = (i == n - 1);
            b.user = lfsr_bit();
            beats.push_back(b);
        end
    endtask

    task automatic check(input string name, input logic [135:0] got, input logic [135:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got %0h expected %0h", name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        tests_run++;
        if (errors == err_start) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err_start);
        end
    endtask

    // Called on a falling edge, returns on the falling edge after the transfer
    task automatic send_hdr(input udp_echo_pkg::udp_hdr_t h);
        int   waited;
        logic taken;
        waited       = 0;
        taken        = 1'b0;
        rx_hdr       = h;
        rx_hdr_valid = 1'b1;
        while (!taken && waited < HANDSHAKE_LIMIT) begin
            #1;
            taken = rx_hdr_ready;
            waited++;
            @(negedge clk);
        end
        rx_hdr_valid = 1'b0;
        if (!taken) begin
            errors++;
            $display("header was never accepted, rx_hdr_ready stayed low");
        end
    endtask

    task automatic send_beats(input udp_echo_pkg::payload_beat_t beats[$]);
        int   waited;
        logic taken;
        foreach (beats[i]) begin
            waited           = 0;
            taken            = 1'b0;
            rx_payload       = beats[i];
            rx_payload_valid = 1'b1;
            while (!taken && waited < HANDSHAKE_LIMIT) begin
                #1;
                taken = rx_payload_ready;
                if (!taken) begin
                    saw_rx_stall = 1'b1;
                end
                waited++;
                @(negedge clk);
            end
            if (!taken) begin
                errors++;
                $display("payload beat %0d was never accepted", i);
            end
        end
        rx_payload_valid = 1'b0;
    endtask

    task automatic wait_outputs(input int n_hdr, input int n_beats);
        int waited;
        waited = 0;
        while ((hdr_q.size() < n_hdr || beat_q.size() < n_beats) && waited < HANDSHAKE_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (waited == HANDSHAKE_LIMIT) begin
            errors++;
            $display("timed out waiting for %0d reply headers and %0d beats", n_hdr, n_beats);
        end
        // A few idle cycles so that extra outputs would show up
        repeat (3) @(negedge clk);
        check("reply header count", hdr_q.size(), n_hdr);
        check("output beat count", beat_q.size(), n_beats);
    endtask

    task automatic check_reply(input udp_echo_pkg::reply_hdr_t got,
                               input udp_echo_pkg::udp_hdr_t sent);
        check("tx_hdr.ttl", got.ttl, 8'd64);
        check("tx_hdr.source_ip", got.source_ip, 32'hC0A8_0180);
        check("tx_hdr.dest_ip", got.dest_ip, sent.source_ip);
        check("tx_hdr.source_port", got.source_port, sent.dest_port);
        check("tx_hdr.dest_port", got.dest_port, sent.source_port);
        check("tx_hdr.length", got.length, sent.length);
        check("tx_hdr.checksum", got.checksum, 16'h0000);
    endtask

    task automatic compare_beats(input udp_echo_pkg::payload_beat_t beats[$]);
        udp_echo_pkg::payload_beat_t got;
        foreach (beats[i]) begin
            if (beat_q.size() == 0) begin
                break;
            end
            got = beat_q.pop_front();
            check($sformatf("tx_payload[%0d].data", i), got.data, beats[i].data);
            check($sformatf("tx_payload[%0d].keep", i), got.keep, beats[i].keep);
            check($sformatf("tx_payload[%0d].last", i), got.last, beats[i].last);
            check($sformatf("tx_payload[%0d].user", i), got.user, beats[i].user);
        end
        beat_q = {};
    endtask

    // One matching frame end to end, with its reply checked
    task automatic run_echo(input int n, output udp_echo_pkg::beat_data_t first_data);
        udp_echo_pkg::udp_hdr_t      h;
        udp_echo_pkg::payload_beat_t beats[$];
        h = make_hdr(16'd1234);
        build_frame(n, beats);
        first_data = beats[0].data;
        send_hdr(h);
        send_beats(beats);
        wait_outputs(1, n);
        if (hdr_q.size() > 0) begin
            check_reply(hdr_q.pop_front(), h);
        end
        hdr_q = {};
        compare_beats(beats);
    endtask

    // Sampled while reset is still held, after two rising edges
    task automatic reset_values();
        int err_start;
        err_start = errors;
        repeat (2) @(posedge clk);
        @(negedge clk);
        #1;
        check("rx_hdr_ready", rx_hdr_ready, 1'b0);
        check("tx_hdr_valid", tx_hdr_valid, 1'b0);
        check("tx_payload_valid", tx_payload_valid, 1'b0);
        check("rx_payload_ready", rx_payload_ready, 1'b0);
        check("led", led, 8'h00);
        report_test("reset_state", err_start);
    endtask

    task automatic dropped_frame();
        int                          err_start;
        udp_echo_pkg::udp_hdr_t      h;
        udp_echo_pkg::payload_beat_t beats[$];
        udp_echo_pkg::beat_data_t    first;
        err_start = errors;
        h = make_hdr(16'd80);
        build_frame(4, beats);
        send_hdr(h);
        send_beats(beats);
        repeat (8) @(negedge clk);
        check("reply header count", hdr_q.size(), 0);
        check("output beat count", beat_q.size(), 0);
        run_echo(3, first);
        report_test("dropped_frame", err_start);
    endtask

    task automatic payload_backpressure();
        int                          err_start;
        int                          cycle;
        logic                        r0;
        logic                        r1;
        udp_echo_pkg::udp_hdr_t      h;
        udp_echo_pkg::payload_beat_t beats[$];
        err_start    = errors;
        saw_rx_stall = 1'b0;
        h = make_hdr(16'd1234);
        build_frame(20, beats);
        fork
            begin
                send_hdr(h);
                send_beats(beats);
            end
            begin
                // Stalled long enough to fill the FIFO, then ready one cycle in four
                for (cycle = 0; beat_q.size() < 20 && cycle < 2 * HANDSHAKE_LIMIT; cycle++) begin
                    r0 = lfsr_bit();
                    r1 = lfsr_bit();
                    tx_payload_ready = (cycle >= 20) && r0 && r1;
                    @(negedge clk);
                end
                tx_payload_ready = 1'b1;
            end
        join
        wait_outputs(1, 20);
        if (hdr_q.size() > 0) begin
            check_reply(hdr_q.pop_front(), h);
        end
        hdr_q = {};
        compare_beats(beats);
        check("rx_payload_ready seen low", saw_rx_stall, 1'b1);
        report_test("payload_backpressure", err_start);
    endtask

    task automatic header_backpressure();
        int                          err_start;
        udp_echo_pkg::udp_hdr_t      h_a;
        udp_echo_pkg::udp_hdr_t      h_b;
        udp_echo_pkg::payload_beat_t beats_a[$];
        udp_echo_pkg::payload_beat_t beats_b[$];
        err_start    = errors;
        tx_hdr_ready = 1'b0;
        h_a = make_hdr(16'd1234);
        h_b = make_hdr(16'd1234);
        build_frame(2, beats_a);
        build_frame(2, beats_b);
        send_hdr(h_a);
        send_beats(beats_a);
        rx_hdr       = h_b;
        rx_hdr_valid = 1'b1;
        repeat (6) begin
            #1;
            check("rx_hdr_ready while reply waits", rx_hdr_ready, 1'b0);
            check("tx_hdr_valid while reply waits", tx_hdr_valid, 1'b1);
            @(negedge clk);
        end
        tx_hdr_ready = 1'b1;
        send_hdr(h_b);
        check("replies taken when second header accepted", hdr_q.size(), 1);
        send_beats(beats_b);
        wait_outputs(2, 4);
        if (hdr_q.size() == 2) begin
            check_reply(hdr_q[0], h_a);
            check_reply(hdr_q[1], h_b);
        end
        hdr_q = {};
        foreach (beats_b[i]) begin
            beats_a.push_back(beats_b[i]);
        end
        compare_beats(beats_a);
        report_test("header_backpressure", err_start);
    endtask

    initial begin
        udp_echo_pkg::beat_data_t first;
        int                       err_start;
        rx_hdr           = '0;
        rx_hdr_valid     = 1'b0;
        rx_payload       = '0;
        rx_payload_valid = 1'b0;
        tx_hdr_ready     = 1'b1;
        tx_payload_ready = 1'b1;
        reset_values();
        wait (rst === 1'b0);
        @(negedge clk);
        err_start = errors;
        run_echo(5, first);
        report_test("matching_frame", err_start);
        dropped_frame();
        payload_backpressure();
        header_backpressure();
        err_start = errors;
        run_echo(4, first);
        run_echo(3, first);
        check("led", led, first[7:0]);
        report_test("led", err_start);
        $display("tests run %0d, tests failed %0d, checks %0d, mismatches %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- udp_echo.f
hw/udp_echo_pkg.sv
hw/echo_ctrl.sv
hw/reply_hdr_builder.sv
hw/payload_fifo.sv
hw/led_capture.sv
hw/udp_echo_core.sv
tests/tb_clock_gen.sv
tests/udp_echo_tb.sv
